/* compile.f */
+incdir+tb
verilog/floatPkg.sv
verilog/busPkg.sv
verilog/floatMult.sv
verilog/floatAdd.sv
verilog/neuronNode.sv
verilog/nodeRegs.sv
verilog/neuronTop.sv
tb/neuronTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= neuronTb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits with a failing status on any $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb/neuronTbTasks.svh */
`ifndef NEURON_TB_TASKS_SVH
`define NEURON_TB_TASKS_SVH

// Waits for ack in mid cycle and closes the access on the next rising edge
task automatic finishAccess();
	@(negedge clk);
	while (!wbRsp.ack)
		@(negedge clk);
	@(posedge clk);
	wbReq.cyc <= 1'b0;
	wbReq.stb <= 1'b0;
	wbReq.we <= 1'b0;
	checkRead <= 1'b0;
endtask

task automatic busWrite(input logic [7:0] adr, input logic [31:0] data, input logic [3:0] sel = 4'hF);
	@(posedge clk);
	wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: data, sel: sel};
	finishAccess();
endtask

// The read data is compared by the readMatch assertion at the ack edge
task automatic expectRead(input string name, input logic [7:0] adr, input logic [31:0] expected);
	@(posedge clk);
	testName = name;
	expData <= expected;
	checkRead <= 1'b1;
	wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: 4'hF};
	finishAccess();
endtask

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// Integer from -limit to limit
function automatic int drawInt(input int limit);
	rngState = xorshift(rngState);
	return int'(rngState % (2 * limit + 1)) - limit;
endfunction

// Small integers are exact, so the mantissa is the magnitude below its leading one
function automatic float32T intToFloat(input int value);
	int mag;
	int msb;
	float32T f;
	mag = (value < 0) ? -value : value;
	msb = 0;
	for (int i = 0; i < 24; i++)
	begin
		if (mag[i])
			msb = i;
	end
	if (mag == 0)
		return FloatZero;
	f = '{sign: value < 0, exp: 8'(ExpBias + msb), man: 23'(mag << (23 - msb))};
	return f;
endfunction

function automatic logic [31:0] expectedResult();
	int acc;
	acc = biasVal;
	for (int i = 0; i < NumInputs; i++)
		acc += actVal[i] * weightVal[i];
	return intToFloat((acc < 0) ? 0 : acc); // ReLU
endfunction

`endif

/* tb/neuronTb.sv */
module neuronTb import busPkg::*, floatPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumInputs = 15;
	localparam int RandomRuns = 40;
	localparam int CyclesPerAccess = 3;
	localparam int AccessesPerRun = 2 * NumInputs + 4; // Operands, bias, start, status and result
	// Directed tests cost fewer accesses than twelve runs
	localparam int TimeoutCycles = (RandomRuns + 12) * AccessesPerRun * CyclesPerAccess + 100;

	logic clk;
	logic rstN;
	wbReqT wbReq;
	wbRspT wbRsp;
	logic checkRead;
	logic [31:0] expData;
	string testName;
	int cycleCount = 0;
	logic [31:0] rngState;
	int actVal [NumInputs];
	int weightVal [NumInputs];
	int biasVal;
	logic [31:0] fillWords [2*NumInputs+1];

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	neuronTop #(.NumInputs(NumInputs)) neuronTop_i
	(
		.clk(clk),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	`include "neuronTbTasks.svh"

	task automatic abortRun();
		$display("Test FAILED");
		$fatal(1);
	endtask

	readMatch: assert property (@(posedge clk) disable iff (!rstN)
		checkRead && wbRsp.ack && !wbReq.we |-> wbRsp.dat == expData)
	else
	begin
		$display("mismatch %s expected %h actual %h", testName, $sampled(expData),
			$sampled(wbRsp.dat));
		abortRun();
	end

	ackPrompt: assert property (@(posedge clk) disable iff (!rstN) $rose(wbReq.stb) |=> wbRsp.ack)
	else
	begin
		$display("no ack on the cycle after the slave sampled stb");
		abortRun();
	end

	ackOnce: assert property (@(posedge clk) disable iff (!rstN) wbRsp.ack |=> !wbRsp.ack)
	else
	begin
		$display("ack stayed high for more than one cycle");
		abortRun();
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TimeoutCycles)
		begin
			$display("timeout after %0d cycles without reaching the end of the tests", cycleCount);
			abortRun();
		end
	end

	// Activations first, then weights, then the bias
	function automatic logic [7:0] wordAdr(input int idx);
		if (idx < NumInputs)
			return ActBase + 8'(4 * idx);
		else if (idx < 2 * NumInputs)
			return WeightBase + 8'(4 * (idx - NumInputs));
		return BiasAdr;
	endfunction

	task automatic checkReadback();
		for (int i = 0; i < 2 * NumInputs + 1; i++)
		begin
			rngState = xorshift(rngState);
			fillWords[i] = rngState;
			busWrite(wordAdr(i), fillWords[i]);
		end
		for (int i = 0; i < 2 * NumInputs + 1; i++)
			expectRead($sformatf("readback word %0d", i), wordAdr(i), fillWords[i]);
		busWrite(ActBase, 32'h11223344);
		busWrite(ActBase, 32'hAABBCCDD, 4'b0101); // Bytes 0 and 2 only
		expectRead("partial write", ActBase, 32'h11BB33DD);
		expectRead("unmapped word", 8'h90, 32'd0);
		expectRead("activation past the last input", ActBase + 8'(4 * NumInputs), 32'd0);
	endtask

	task automatic restartNode(input string name);
		busWrite(CtrlAdr, 32'd1);
		expectRead({name, " done"}, StatusAdr, 32'd1);
		expectRead(name, ResultAdr, expectedResult());
	endtask

	task automatic loadAndRun(input string name);
		for (int i = 0; i < NumInputs; i++)
		begin
			busWrite(wordAdr(i), intToFloat(actVal[i]));
			busWrite(wordAdr(NumInputs + i), intToFloat(weightVal[i]));
		end
		busWrite(BiasAdr, intToFloat(biasVal));
		restartNode(name);
	endtask

	initial
	begin
		rstN <= 1'b0;
		wbReq <= '0;
		checkRead <= 1'b0;
		expData <= '0;
		testName = "none";
		rngState = 32'd68;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;

		expectRead("reset status", StatusAdr, 32'd0);
		expectRead("reset result", ResultAdr, 32'd0);
		expectRead("reset bias", BiasAdr, 32'd0);
		checkReadback();

		// Zero activations and zero weights mixed into a positive sum
		for (int i = 0; i < NumInputs; i++)
		begin
			actVal[i] = (i % 3 == 0) ? 0 : i % 8 + 1;
			weightVal[i] = i % 5 - 1;
		end
		biasVal = 5;
		loadAndRun("positive sum");
		expectRead("done keeps result", ResultAdr, expectedResult());

		weightVal[NumInputs-1] = 8;
		busWrite(wordAdr(2 * NumInputs - 1), intToFloat(weightVal[NumInputs-1]));
		restartNode("second start");

		for (int i = 0; i < NumInputs; i++)
		begin
			actVal[i] = i % 8 + 1;
			weightVal[i] = -(i % 4) - 1;
		end
		biasVal = 3;
		loadAndRun("negative sum");

		for (int i = 0; i < NumInputs; i++)
		begin
			actVal[i] = 2;
			weightVal[i] = i % 5 - 2; // Each group of five cancels
		end
		biasVal = 0;
		loadAndRun("zero sum");

		for (int run = 0; run < RandomRuns; run++)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				actVal[i] = drawInt(8);
				weightVal[i] = drawInt(8);
			end
			biasVal = drawInt(64);
			loadAndRun($sformatf("random run %0d", run));
		end

		repeat (3) @(posedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

/* verilog/neuronTop.sv */
module neuronTop import busPkg::*, floatPkg::*;
#(
	parameter int NumInputs = 15
)
(
	input logic clk,
	input logic rstN,
	input wbReqT wbReq,
	output wbRspT wbRsp
);

	float32T [NumInputs-1:0] acts;
	float32T [NumInputs-1:0] weights;
	float32T bias;
	float32T result;
	logic start;
	logic resultValid;

	nodeRegs #(.NumInputs(NumInputs)) nodeRegs_i
	(
		.clk(clk),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.acts(acts),
		.weights(weights),
		.bias(bias),
		.start(start),
		.result(result),
		.resultValid(resultValid)
	);

	neuronNode #(.NumInputs(NumInputs)) neuronNode_i
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.acts(acts),
		.weights(weights),
		.bias(bias),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

/* verilog/nodeRegs.sv */
module nodeRegs import busPkg::*, floatPkg::*;
#(
	parameter int NumInputs = 15
)
(
	input logic clk,
	input logic rstN,
	input wbReqT wbReq,
	output wbRspT wbRsp,
	output float32T [NumInputs-1:0] acts,
	output float32T [NumInputs-1:0] weights,
	output float32T bias,
	output logic start,
	input float32T result,
	input logic resultValid
);

	logic ackQ;
	logic ack;
	logic wrEn;
	logic [3:0] wordIdx;
	logic actHit;
	logic weightHit;
	logic done;
	float32T resultReg;
	logic [31:0] readData;

	function automatic logic [31:0] mergeBytes
	(
		input logic [31:0] old,
		input logic [31:0] data,
		input logic [3:0] sel
	);
		logic [31:0] merged;
		merged = old;
		for (int i = 0; i < 4; i++)
		begin
			if (sel[i])
				merged[8*i +: 8] = data[8*i +: 8];
		end
		return merged;
	endfunction

	assign wordIdx = wbReq.adr[5:2];
	assign actHit = (wbReq.adr[7:6] == ActBase[7:6]) && (wordIdx < NumInputs);
	assign weightHit = (wbReq.adr[7:6] == WeightBase[7:6]) && (wordIdx < NumInputs);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			ackQ <= 1'b0;
		else
			ackQ <= wbReq.cyc && wbReq.stb && !ackQ; // One cycle per access
	end

	assign ack = ackQ && wbReq.cyc && wbReq.stb; // Drops at once if the host withdraws stb
	assign wrEn = ack && wbReq.we;
	assign start = wrEn && (wbReq.adr == CtrlAdr) && wbReq.sel[0] && wbReq.dat[0];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			acts <= '0;
			weights <= '0;
			bias <= FloatZero;
		end
		else if (wrEn)
		begin
			if (actHit)
				acts[wordIdx] <= mergeBytes(acts[wordIdx], wbReq.dat, wbReq.sel);
			else if (weightHit)
				weights[wordIdx] <= mergeBytes(weights[wordIdx], wbReq.dat, wbReq.sel);
			else if (wbReq.adr == BiasAdr)
				bias <= mergeBytes(bias, wbReq.dat, wbReq.sel);
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			done <= 1'b0;
			resultReg <= FloatZero;
		end
		else
		begin
			// A start in the same cycle as an older result keeps done low
			if (start)
				done <= 1'b0;
			else if (resultValid)
				done <= 1'b1;
			if (resultValid)
				resultReg <= result;
		end
	end

	// Read data follows the registers during the ack cycle
	always_comb
	begin
		readData = '0;
		if (actHit)
			readData = acts[wordIdx];
		else if (weightHit)
			readData = weights[wordIdx];
		else
		begin
			case (wbReq.adr)
				BiasAdr: readData = bias;
				StatusAdr: readData = {31'd0, done};
				ResultAdr: readData = resultReg;
				default: readData = '0; // Control and unmapped words
			endcase
		end
	end

	assign wbRsp = '{ack: ack, dat: readData};

endmodule

/* verilog/neuronNode.sv */
module neuronNode import floatPkg::*;
#(
	parameter int NumInputs = 15
)
(
	input logic clk,
	input logic rstN,
	input logic start,
	input float32T [NumInputs-1:0] acts,
	input float32T [NumInputs-1:0] weights,
	input float32T bias,
	output float32T result,
	output logic resultValid
);

	// Products plus bias padded up to a power of two
	localparam int Leaves = 1 << $clog2(NumInputs + 1);

	// Heap order where node n adds nodes 2n+1 and 2n+2 and the root is node 0
	float32T treeNode [2*Leaves-1];
	float32T reluSum;

	for (genvar i = 0; i < Leaves; i++)
	begin : genLeaf
		if (i < NumInputs)
		begin : genMult
			floatMult mult_i
			(
				.a(acts[i]),
				.b(weights[i]),
				.prod(treeNode[Leaves-1+i])
			);
		end
		else if (i == NumInputs)
		begin : genBias
			assign treeNode[Leaves-1+i] = bias;
		end
		else
		begin : genPad
			assign treeNode[Leaves-1+i] = FloatZero;
		end
	end

	for (genvar n = 0; n < Leaves-1; n++)
	begin : genAdd
		floatAdd add_i
		(
			.a(treeNode[2*n+1]),
			.b(treeNode[2*n+2]),
			.sum(treeNode[n])
		);
	end

	assign reluSum = treeNode[0].sign ? FloatZero : treeNode[0]; // ReLU

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			resultValid <= 1'b0;
		else
			resultValid <= start;
	end

	// Operands are sampled on the start cycle
	always_ff @(posedge clk)
	begin
		if (start)
			result <= reluSum;
	end

endmodule

/* verilog/floatAdd.sv */
module floatAdd import floatPkg::*;
(
	input float32T a,
	input float32T b,
	output float32T sum
);

	float32T larger;
	float32T smaller;
	logic [26:0] manLarge;
	logic [26:0] manSmall;
	logic [26:0] manShift;
	logic [7:0] expDiff;
	logic [27:0] manSum;
	logic [27:0] manNorm;
	logic [4:0] lzCount;
	logic signed [9:0] expOut;

	// Larger magnitude first so a subtraction never goes negative
	always_comb
	begin
		if ({a.exp, a.man} >= {b.exp, b.man})
		begin
			larger = a;
			smaller = b;
		end
		else
		begin
			larger = b;
			smaller = a;
		end
	end

	// Hidden bit plus three guard bits below the mantissa
	always_comb
	begin
		manLarge = (larger.exp != '0) ? {1'b1, larger.man, 3'b000} : '0;
		manSmall = (smaller.exp != '0) ? {1'b1, smaller.man, 3'b000} : '0;
		expDiff = larger.exp - smaller.exp;
		manShift = manSmall >> expDiff; // Bits shifted out are dropped

		if (larger.sign ^ smaller.sign)
			manSum = {1'b0, manLarge} - {1'b0, manShift};
		else
			manSum = {1'b0, manLarge} + {1'b0, manShift};
	end

	always_comb
	begin
		lzCount = 5'd0;
		for (int i = 0; i < 28; i++)
		begin
			if (manSum[i])
				lzCount = 5'(27 - i); // Highest set bit wins
		end
	end

	always_comb
	begin
		manNorm = manSum << lzCount;

		// A carry out gives no leading zero and bumps the exponent
		expOut = 10'(larger.exp) + 10'd1 - 10'(lzCount);

		if (manSum == '0 || expOut <= 0)
			sum = FloatZero;
		else
			sum = '{sign: larger.sign, exp: expOut[7:0], man: manNorm[26:4]};
	end

endmodule

/* verilog/floatMult.sv */
module floatMult import floatPkg::*;
(
	input float32T a,
	input float32T b,
	output float32T prod
);

	logic [23:0] manA;
	logic [23:0] manB;
	logic [47:0] manProd;
	logic signed [9:0] expOut;
	logic [22:0] manOut;

	always_comb
	begin
		manA = {1'b1, a.man};
		manB = {1'b1, b.man};
		manProd = manA * manB;

		// Wide enough to see an underflow below zero
		expOut = 10'(a.exp) + 10'(b.exp) - 10'(ExpBias);

		// Product of two values in [1,2) lies in [1,4)
		if (manProd[47])
		begin
			manOut = manProd[46:24];
			expOut = expOut + 10'sd1;
		end
		else
		begin
			manOut = manProd[45:23];
		end

		if (a.exp == '0 || b.exp == '0 || expOut <= 0)
			prod = FloatZero; // Zero and subnormal operands flush here too
		else
			prod = '{sign: a.sign ^ b.sign, exp: expOut[7:0], man: manOut};
	end

endmodule

/* verilog/busPkg.sv */
package busPkg;

	localparam int AdrWidth = 8;
	localparam int DataWidth = 32;

	// Host side of a Wishbone classic cycle
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [AdrWidth-1:0] adr; // Byte address
		logic [DataWidth-1:0] dat;
		logic [DataWidth/8-1:0] sel;
	} wbReqT;

	typedef struct packed
	{
		logic ack;
		logic [DataWidth-1:0] dat;
	} wbRspT;

	// Register map in byte addresses
	localparam logic [AdrWidth-1:0] ActBase = 8'h00;
	localparam logic [AdrWidth-1:0] WeightBase = 8'h40;
	localparam logic [AdrWidth-1:0] BiasAdr = 8'h80;
	localparam logic [AdrWidth-1:0] CtrlAdr = 8'h84; // Bit 0 starts a computation
	localparam logic [AdrWidth-1:0] StatusAdr = 8'h88; // Bit 0 is done
	localparam logic [AdrWidth-1:0] ResultAdr = 8'h8C;

endpackage

/* verilog/floatPkg.sv */
package floatPkg;

	localparam int ExpWidth = 8;
	localparam int ManWidth = 23;

	// IEEE single precision word split into its fields
	typedef struct packed
	{
		logic sign;
		logic [ExpWidth-1:0] exp;
		logic [ManWidth-1:0] man;
	} float32T;

	localparam int ExpBias = 127;

	localparam float32T FloatZero = '{sign: 1'b0, exp: '0, man: '0}; // Positive zero

endpackage
